/* design/gl_matrix_pkg.sv */
`default_nettype none

package gl_matrix_pkg;

    ////////////////////////////////////////////////////////////
    // element, row and matrix types
    ////////////////////////////////////////////////////////////

    typedef logic signed [31:0] fix_t;      // Q16.16
    typedef logic [127:0]       mat_row_t;  // element 0 in bits 127:96
    typedef logic [511:0]       matrix_t;   // row 0 in bits 511:384
    typedef logic [1:0]         row_idx_t;
    typedef logic               mat_mode_t; // 0 modelview, 1 projection
    typedef logic [2:0]         mat_op_t;
    typedef logic [2:0]         level_t;    // matrices on the stack minus one

    localparam fix_t FIX_ONE = 32'h0001_0000;

    localparam mat_op_t OP_LOAD    = 3'd0;
    localparam mat_op_t OP_LOAD_ID = 3'd1;
    localparam mat_op_t OP_PUSH    = 3'd2;
    localparam mat_op_t OP_POP     = 3'd3;
    localparam mat_op_t OP_MULT    = 3'd4;

    localparam int MV_DEPTH = 8;
    localparam int PJ_DEPTH = 2;

    typedef struct packed {
        mat_op_t   op;
        mat_mode_t mode;
        matrix_t   operand;
    } mat_cmd_t;

    typedef struct packed {
        logic   refused;
        level_t level;     // level after the command
    } mat_resp_t;

    ////////////////////////////////////////////////////////////
    // row and element pick helpers
    ////////////////////////////////////////////////////////////

    function automatic mat_row_t get_row(input matrix_t m, input row_idx_t r);
        mat_row_t rows [4];
        {rows[0], rows[1], rows[2], rows[3]} = m;
        return rows[r];
    endfunction

    function automatic fix_t get_elem(input mat_row_t row, input row_idx_t e);
        fix_t el [4];
        {el[0], el[1], el[2], el[3]} = row;
        return el[e];
    endfunction

endpackage

`default_nettype wire

/* design/matrix_stack.sv */
`timescale 1ns/100ps
`default_nettype none

// two matrix stacks, growing up, one matrix = four consecutive rows
module matrix_stack (
    input  logic                     clk,
    input  logic                     arst_n,
    input  gl_matrix_pkg::mat_mode_t st_mode,
    input  logic                     wr_en,
    input  gl_matrix_pkg::mat_mode_t wr_mode,
    input  gl_matrix_pkg::row_idx_t  wr_row,
    input  gl_matrix_pkg::mat_row_t  wr_data,
    input  logic                     id_en,
    input  logic                     push_en,
    input  logic                     pop_en,
    input  gl_matrix_pkg::mat_mode_t view_mode,
    output gl_matrix_pkg::matrix_t   top,
    output gl_matrix_pkg::matrix_t   cur_top,
    output gl_matrix_pkg::level_t    level,
    output logic                     full,
    output logic                     single
);
    import gl_matrix_pkg::*;

    localparam matrix_t ID_MAT = {
        FIX_ONE, 96'd0,
        32'd0,   FIX_ONE, 64'd0,
        64'd0,   FIX_ONE, 32'd0,
        96'd0,   FIX_ONE
    };

    matrix_t stk_top    [2];
    level_t  stk_lvl    [2];
    logic    stk_full   [2];
    logic    stk_single [2];

    ////////////////////////////////////////////////////////////
    // per-stack storage, g = 0 modelview, g = 1 projection
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < 2; g++)
    begin : g_stack
        localparam int DEPTH = (g == 0) ? MV_DEPTH : PJ_DEPTH;
        localparam int AW    = $clog2(DEPTH * 4);

        mat_row_t      mem [DEPTH * 4];
        level_t        lvl;
        logic [AW-1:0] base;     // row 0 of the top matrix
        logic [AW-1:0] nbase;    // row 0 of the slot above
        logic          sel_st;
        logic          sel_wr;

        assign sel_st = (st_mode == mat_mode_t'(g));
        assign sel_wr = (wr_mode == mat_mode_t'(g));
        assign base   = AW'({lvl, 2'b00});
        assign nbase  = AW'({lvl + 3'd1, 2'b00});

        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                lvl <= '0;
            end
            else if (push_en && sel_st)
            begin
                lvl <= lvl + 3'd1;
            end
            else if (pop_en && sel_st)
            begin
                lvl <= lvl - 3'd1;   // old top just goes stale
            end
        end

        always_ff @(posedge clk)
        begin
            if (push_en && sel_st)
            begin
                for (int r = 0; r < 4; r++)
                begin
                    mem[nbase + AW'(r)] <= mem[base + AW'(r)];  // duplicate top
                end
            end
            else if (id_en && sel_st)
            begin
                for (int r = 0; r < 4; r++)
                begin
                    mem[base + AW'(r)] <= get_row(ID_MAT, row_idx_t'(r));
                end
            end
            else if (wr_en && sel_wr)
            begin
                mem[base + AW'(wr_row)] <= wr_data;
            end
        end

        // peek, combinational
        assign stk_top[g]    = {mem[base], mem[base + AW'(1)],
                                mem[base + AW'(2)], mem[base + AW'(3)]};
        assign stk_lvl[g]    = lvl;
        assign stk_full[g]   = (lvl == level_t'(DEPTH - 1));
        assign stk_single[g] = (lvl == '0);
    end

    assign top     = stk_top[view_mode];
    assign cur_top = stk_top[st_mode];
    assign level   = stk_lvl[st_mode];
    assign full    = stk_full[st_mode];
    assign single  = stk_single[st_mode];

    ////////////////////////////////////////////////////////////
    // checks on the controller strobes
    ////////////////////////////////////////////////////////////

    a_no_push_full : assert property (
        @(posedge clk) disable iff (!arst_n) push_en |-> !full)
        else $error("push on a full stack");

    a_no_pop_single : assert property (
        @(posedge clk) disable iff (!arst_n) pop_en |-> !single)
        else $error("pop on a one-deep stack");

    a_one_op : assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0({wr_en, id_en, push_en, pop_en}))
        else $error("more than one stack operation in a cycle");

endmodule

`default_nettype wire

/* design/matrix_row_mult.sv */
`timescale 1ns/100ps
`default_nettype none

// row vector times 4x4 matrix, Q16.16, one cycle latency
module matrix_row_mult (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    go,
    input  gl_matrix_pkg::mat_row_t row_in,
    input  gl_matrix_pkg::matrix_t  operand,
    output logic                    valid,
    output gl_matrix_pkg::mat_row_t row_out
);
    import gl_matrix_pkg::*;

    mat_row_t prod_row;

    // out[j] = sum over k of row_in[k] * operand[k][j]
    always_comb
    begin : mac
        fix_t               a;
        fix_t               b;
        fix_t               acc;
        fix_t               res [4];
        logic signed [63:0] prod;

        for (int j = 0; j < 4; j++)
        begin
            acc = '0;
            for (int k = 0; k < 4; k++)
            begin
                a    = get_elem(row_in, row_idx_t'(k));
                b    = get_elem(get_row(operand, row_idx_t'(k)), row_idx_t'(j));
                prod = 64'(a) * 64'(b);
                acc  = acc + prod[47:16];   // truncate back to Q16.16, sum wraps
            end
            res[j] = acc;
        end
        prod_row = {res[0], res[1], res[2], res[3]};
    end

    always_ff @(posedge clk)
    begin
        if (go)
        begin
            row_out <= prod_row;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid <= 1'b0;
        end
        else
        begin
            valid <= go;   // exactly one cycle after go
        end
    end

endmodule

`default_nettype wire

/* design/matrix_cmd_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module matrix_cmd_ctrl (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cmd_req,
    input  gl_matrix_pkg::mat_cmd_t   cmd,
    output logic                      cmd_ack,
    output gl_matrix_pkg::mat_resp_t  resp,
    // stack side
    output gl_matrix_pkg::mat_mode_t  st_mode,
    output logic                      wr_en,
    output gl_matrix_pkg::mat_mode_t  wr_mode,
    output gl_matrix_pkg::row_idx_t   wr_row,
    output gl_matrix_pkg::mat_row_t   wr_data,
    output logic                      id_en,
    output logic                      push_en,
    output logic                      pop_en,
    input  logic                      full,
    input  logic                      single,
    input  gl_matrix_pkg::matrix_t    cur_top,
    input  gl_matrix_pkg::level_t     level,
    // multiplier side
    output logic                      mul_go,
    output gl_matrix_pkg::mat_row_t   mul_row,
    output gl_matrix_pkg::matrix_t    mul_operand,
    input  logic                      mul_valid,
    input  gl_matrix_pkg::mat_row_t   mul_out
);
    import gl_matrix_pkg::*;

    typedef enum logic [2:0] {IDLE, LOAD_ROWS, MULT_ROWS, ACK, WAIT_REL} state_t;

    state_t   state;
    state_t   state_nxt;
    mat_cmd_t cmd_q;
    row_idx_t row_q;       // row being written (load) or issued (mult)
    logic     refused_q;
    logic     accept;
    logic     refuse;

    assign accept = (state == IDLE) && cmd_req;   // cmd_ack is always low in IDLE
    assign refuse = ((cmd.op == OP_PUSH) && full) || ((cmd.op == OP_POP) && single);

    // stack flags follow the incoming mode while idle
    assign st_mode = (state == IDLE) ? cmd.mode : cmd_q.mode;

    ////////////////////////////////////////////////////////////
    // single-cycle ops fire on accept
    ////////////////////////////////////////////////////////////

    assign push_en = accept && (cmd.op == OP_PUSH) && !full;
    assign pop_en  = accept && (cmd.op == OP_POP) && !single;
    assign id_en   = accept && (cmd.op == OP_LOAD_ID);

    // row port, mult writes land one row behind the issue index
    assign wr_en   = (state == LOAD_ROWS) || ((state == MULT_ROWS) && mul_valid);
    assign wr_mode = cmd_q.mode;
    assign wr_row  = (state == MULT_ROWS) ? row_q - 2'd1 : row_q;
    assign wr_data = (state == MULT_ROWS) ? mul_out : get_row(cmd_q.operand, row_q);

    // stop issuing once row 3 comes back
    assign mul_go      = (state == MULT_ROWS) && !(mul_valid && (row_q == 2'd0));
    assign mul_row     = get_row(cur_top, row_q);
    assign mul_operand = cmd_q.operand;

    assign cmd_ack = (state == ACK);
    assign resp    = '{refused: refused_q, level: level};

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (cmd_req)
                begin
                    case (cmd.op)
                        OP_LOAD: state_nxt = LOAD_ROWS;
                        OP_MULT: state_nxt = MULT_ROWS;
                        default: state_nxt = ACK;     // push, pop, identity done already
                    endcase
                end
            end
            LOAD_ROWS:
            begin
                if (row_q == 2'd3)
                begin
                    state_nxt = ACK;
                end
            end
            MULT_ROWS:
            begin
                if (mul_valid && (row_q == 2'd0))
                begin
                    state_nxt = ACK;                  // row 3 written this cycle
                end
            end
            ACK:
            begin
                if (!cmd_req)
                begin
                    state_nxt = WAIT_REL;
                end
            end
            WAIT_REL:  state_nxt = IDLE;              // ack low for a cycle first
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= IDLE;
            row_q     <= '0;
            refused_q <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (accept)
            begin
                row_q     <= '0;
                refused_q <= refuse;
            end
            else if ((state == LOAD_ROWS) || mul_go)
            begin
                row_q <= row_q + 2'd1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cmd_q <= cmd;
        end
    end

    // host must hold the command until it is acknowledged
    a_cmd_stable : assert property (
        @(posedge clk) disable iff (!arst_n) (cmd_req && !cmd_ack) |=> $stable(cmd))
        else $error("cmd changed while req pending");

endmodule

`default_nettype wire

/* design/matrix_unit_top.sv */
`timescale 1ns/100ps
`default_nettype none

module matrix_unit_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     cmd_req,
    input  gl_matrix_pkg::mat_cmd_t  cmd,
    input  gl_matrix_pkg::mat_mode_t view_mode,
    output logic                     cmd_ack,
    output gl_matrix_pkg::mat_resp_t resp,
    output gl_matrix_pkg::matrix_t   top
);
    import gl_matrix_pkg::*;

    // controller <-> stack
    mat_mode_t st_mode;
    logic      wr_en;
    mat_mode_t wr_mode;
    row_idx_t  wr_row;
    mat_row_t  wr_data;
    logic      id_en;
    logic      push_en;
    logic      pop_en;
    logic      full;
    logic      single;
    matrix_t   cur_top;
    level_t    level;

    // controller <-> multiplier
    logic      mul_go;
    mat_row_t  mul_row;
    matrix_t   mul_operand;
    logic      mul_valid;
    mat_row_t  mul_out;

    matrix_cmd_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd_req     (cmd_req),
        .cmd         (cmd),
        .cmd_ack     (cmd_ack),
        .resp        (resp),
        .st_mode     (st_mode),
        .wr_en       (wr_en),
        .wr_mode     (wr_mode),
        .wr_row      (wr_row),
        .wr_data     (wr_data),
        .id_en       (id_en),
        .push_en     (push_en),
        .pop_en      (pop_en),
        .full        (full),
        .single      (single),
        .cur_top     (cur_top),
        .level       (level),
        .mul_go      (mul_go),
        .mul_row     (mul_row),
        .mul_operand (mul_operand),
        .mul_valid   (mul_valid),
        .mul_out     (mul_out)
    );

    matrix_stack u_stack (
        .clk       (clk),
        .arst_n    (arst_n),
        .st_mode   (st_mode),
        .wr_en     (wr_en),
        .wr_mode   (wr_mode),
        .wr_row    (wr_row),
        .wr_data   (wr_data),
        .id_en     (id_en),
        .push_en   (push_en),
        .pop_en    (pop_en),
        .view_mode (view_mode),
        .top       (top),
        .cur_top   (cur_top),
        .level     (level),
        .full      (full),
        .single    (single)
    );

    matrix_row_mult u_mult (
        .clk     (clk),
        .arst_n  (arst_n),
        .go      (mul_go),
        .row_in  (mul_row),
        .operand (mul_operand),
        .valid   (mul_valid),
        .row_out (mul_out)
    );

endmodule

`default_nettype wire

/* bench/matrix_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module matrix_unit_tb;
    import gl_matrix_pkg::*;

    localparam logic [1:0] SEL_NONE = 2'd0;
    localparam logic [1:0] SEL_RAND = 2'd1;   // elements in -4.0 .. 4.0
    localparam logic [1:0] SEL_PAT  = 2'd2;   // fixed ramp in steps of 0.25
    localparam logic [1:0] SEL_ID   = 2'd3;
    localparam mat_mode_t  MV       = 1'b0;
    localparam mat_mode_t  PJ       = 1'b1;
    localparam int         N_CMDS   = 22;
    localparam int         CYCLE_LIMIT = N_CMDS * 20 + 100;

    typedef struct packed {
        mat_op_t    op;
        mat_mode_t  mode;
        logic [1:0] sel;
        logic       exp_ref;
    } entry_t;

    localparam entry_t CMD_LIST [N_CMDS] = '{
        '{OP_LOAD_ID, MV, SEL_NONE, 1'b0},
        '{OP_LOAD,    PJ, SEL_RAND, 1'b0},
        '{OP_LOAD,    MV, SEL_RAND, 1'b0},
        '{OP_LOAD_ID, PJ, SEL_NONE, 1'b0},
        '{OP_MULT,    PJ, SEL_PAT,  1'b0},   // I x A
        '{OP_MULT,    MV, SEL_ID,   1'b0},   // A x I
        '{OP_PUSH,    MV, SEL_NONE, 1'b0},
        '{OP_LOAD,    MV, SEL_RAND, 1'b0},   // modify the copy
        '{OP_MULT,    MV, SEL_RAND, 1'b0},
        '{OP_POP,     MV, SEL_NONE, 1'b0},   // earlier top returns
        '{OP_POP,     MV, SEL_NONE, 1'b1},
        '{OP_PUSH,    PJ, SEL_NONE, 1'b0},
        '{OP_MULT,    PJ, SEL_RAND, 1'b0},
        '{OP_PUSH,    PJ, SEL_NONE, 1'b1},   // projection stack full
        '{OP_POP,     PJ, SEL_NONE, 1'b0},
        '{OP_POP,     PJ, SEL_NONE, 1'b1},
        '{OP_MULT,    MV, SEL_RAND, 1'b0},
        '{OP_PUSH,    MV, SEL_NONE, 1'b0},
        '{OP_PUSH,    MV, SEL_NONE, 1'b0},
        '{OP_MULT,    MV, SEL_RAND, 1'b0},
        '{OP_POP,     MV, SEL_NONE, 1'b0},
        '{OP_LOAD,    PJ, SEL_PAT,  1'b0}
    };

    logic      clk;
    logic      arst_n;
    logic      cmd_req;
    mat_cmd_t  cmd;
    mat_mode_t view_mode;
    logic      cmd_ack;
    mat_resp_t resp;
    matrix_t   top;

    // reference stacks
    matrix_t model_stk [2][8];
    int      model_lvl [2];
    logic    loaded    [2];
    int      errors;
    int      cycles;

    matrix_unit_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .view_mode (view_mode),
        .cmd_ack   (cmd_ack),
        .resp      (resp),
        .top       (top)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles == CYCLE_LIMIT)
        begin
            $display("timeout: command table not finished after %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic fix_t elem_of(input matrix_t m, input int r, input int c);
        return m[511 - 32 * (4 * r + c) -: 32];   // row 0, element 0 at the top
    endfunction

    function automatic matrix_t build_operand(input logic [1:0] sel);
        matrix_t m;
        int      v;
        m = '0;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                case (sel)
                    SEL_RAND: v = int'($urandom % 32'd524289) - 262144;
                    SEL_PAT:  v = (4 * r + c - 7) * 16384;
                    SEL_ID:   v = (r == c) ? int'(FIX_ONE) : 0;
                    default:  v = 0;
                endcase
                m[511 - 32 * (4 * r + c) -: 32] = v;
            end
        end
        return m;
    endfunction

    // Q16.16 product, each term truncated, sum wraps at 32 bits
    function automatic matrix_t mat_mul(input matrix_t a, input matrix_t b);
        matrix_t p;
        fix_t    acc;
        longint  prod;
        p = '0;
        for (int i = 0; i < 4; i++)
        begin
            for (int j = 0; j < 4; j++)
            begin
                acc = '0;
                for (int k = 0; k < 4; k++)
                begin
                    prod = longint'(elem_of(a, i, k)) * longint'(elem_of(b, k, j));
                    acc  = acc + fix_t'(prod >>> 16);
                end
                p[511 - 32 * (4 * i + j) -: 32] = acc;
            end
        end
        return p;
    endfunction

    task automatic update_model(input mat_cmd_t c);
        int m;
        int depth;
        m     = int'(c.mode);
        depth = (c.mode == PJ) ? PJ_DEPTH : MV_DEPTH;
        case (c.op)
            OP_LOAD:
            begin
                model_stk[m][model_lvl[m]] = c.operand;
                loaded[m] = 1'b1;
            end
            OP_LOAD_ID:
            begin
                model_stk[m][model_lvl[m]] = build_operand(SEL_ID);
                loaded[m] = 1'b1;
            end
            OP_PUSH:
            begin
                if (model_lvl[m] < depth - 1)
                begin
                    model_stk[m][model_lvl[m] + 1] = model_stk[m][model_lvl[m]];
                    model_lvl[m]++;
                end
            end
            OP_POP:
            begin
                if (model_lvl[m] > 0)
                begin
                    model_lvl[m]--;
                end
            end
            OP_MULT:  model_stk[m][model_lvl[m]] = mat_mul(model_stk[m][model_lvl[m]], c.operand);
            default:  ;
        endcase
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // one command through the four-phase handshake
    ////////////////////////////////////////////////////////////

    task automatic run_entry(input int idx, input entry_t e);
        mat_cmd_t  c;
        mat_mode_t other;
        int        hold;
        c.op      = e.op;
        c.mode    = e.mode;
        c.operand = build_operand(e.sel);
        other     = ~e.mode;
        hold      = int'($urandom % 32'd4);   // extra cycles with req held
        @(negedge clk);
        cmd       = c;
        view_mode = e.mode;
        cmd_req   = 1'b1;
        while (!cmd_ack) @(negedge clk);
        update_model(c);
        assert (resp.refused == e.exp_ref)
        else report_error($sformatf("cmd %0d refused %0b, expected %0b",
                                    idx, resp.refused, e.exp_ref));
        assert (resp.level == level_t'(model_lvl[e.mode]))
        else report_error($sformatf("cmd %0d level %0d, expected %0d",
                                    idx, resp.level, model_lvl[e.mode]));
        if (loaded[e.mode])
        begin
            assert (top == model_stk[e.mode][model_lvl[e.mode]])
            else report_error($sformatf("cmd %0d top %h, expected %h",
                                        idx, top, model_stk[e.mode][model_lvl[e.mode]]));
        end
        repeat (hold)
        begin
            @(negedge clk);
            assert (cmd_ack)
            else report_error($sformatf("cmd %0d ack dropped with req still high", idx));
        end
        cmd_req = 1'b0;
        @(negedge clk);
        while (cmd_ack) @(negedge clk);
        view_mode = other;   // other stack must be untouched
        @(negedge clk);
        if (loaded[other])
        begin
            assert (top == model_stk[other][model_lvl[other]])
            else report_error($sformatf("cmd %0d other stack top %h, expected %h",
                                        idx, top, model_stk[other][model_lvl[other]]));
        end
    endtask

    initial
    begin
        void'($urandom(32'h6105_c119));
        errors       = 0;
        cycles       = 0;
        arst_n       = 1'b0;
        cmd_req      = 1'b0;
        cmd          = '0;
        view_mode    = MV;
        model_lvl[0] = 0;
        model_lvl[1] = 0;
        loaded[0]    = 1'b0;
        loaded[1]    = 1'b0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (!cmd_ack)
        else report_error("cmd_ack is high right after reset");
        for (int i = 0; i < N_CMDS; i++)
        begin
            run_entry(i, CMD_LIST[i]);
        end
        $display("commands run %0d, errors %0d", N_CMDS, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* matrix_unit.f */
design/gl_matrix_pkg.sv
design/matrix_stack.sv
design/matrix_row_mult.sv
design/matrix_cmd_ctrl.sv
design/matrix_unit_top.sv
bench/matrix_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the matrix unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module matrix_unit_tb -f matrix_unit.f

out=$(./obj_dir/Vmatrix_unit_tb)
echo "$out"
echo "$out" | grep -q "STATUS: PASS"
